// ==== include/dither_defines.svh ====
`ifndef DITHER_DEFINES_SVH
`define DITHER_DEFINES_SVH

// ************************************************************
// video geometry
// ************************************************************

// samples per line period, active plus blanking
`define LINE_TOTAL 24
// active pixels per line
`define ACTIVE_W 16

// ************************************************************
// diffusion kernel and levels
// ************************************************************

// taps in the current line, offsets +1 and +2
`define ROW0_TAPS 2
// taps in each of the two lines below, offsets -2 .. +2
`define ROWN_TAPS 5
// binarisation threshold
`define GRAY_THRESH 128
// top gray level, also the white output
`define GRAY_MAX 255

`endif

// ==== design/dither_pkg.sv ====
package dither_pkg;

    // ************************************************************
    // pixel and arithmetic widths
    // ************************************************************

    // packed rgb pixel, red in the top byte, blue in the low byte
    typedef logic [23:0] rgb_t;

    // one gray level
    typedef logic [7:0] gray_t;

    // gray value while errors are added to it
    // two spare bits hold the overshoot and the sign before clamping
    typedef logic signed [9:0] acc_t;

    // one weighted error term
    typedef logic signed [9:0] err_t;

    // column inside the active line
    typedef logic [11:0] col_t;

endpackage

// ==== design/pix_if.sv ====
// one pixel sample moving between pipeline stages
// no handshake, one sample per clock, every stage takes it
interface pix_if;
    import dither_pkg::*;

    // gray value with the diffused error already folded in
    acc_t gray;
    // active column, only meaningful while de is high
    col_t col;
    // video strobes, carried beside the data
    logic de;
    logic hs;
    logic vs;

    // producing stage
    modport src (
        output gray, col, de, hs, vs
    );

    // consuming stage
    modport dst (
        input gray, col, de, hs, vs
    );

endinterface

// ==== design/luma_stage.sv ====
`include "dither_defines.svh"

module luma_stage (
    input  logic            clk,
    input  logic            rst,
    input  dither_pkg::rgb_t din,
    input  logic            hs_in,
    input  logic            vs_in,
    input  logic            de_in,
    pix_if.src              pix
);
    import dither_pkg::*;

    // gray approximation r/4 + g/2 + b/4, at most 253 so no carry out
    gray_t luma;
    acc_t  gray_q;
    col_t  col_q;
    logic  de_q;
    logic  hs_q;
    logic  vs_q;

    assign luma = (din[23:16] >> 2) + (din[15:8] >> 1) + (din[7:0] >> 2);

    always_ff @(posedge clk) begin
        if (rst) begin
            gray_q <= '0;
            col_q  <= '0;
            de_q   <= 1'b0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
        end else begin
            gray_q <= {2'b00, luma};
            de_q   <= de_in;
            hs_q   <= hs_in;
            vs_q   <= vs_in;
            // rising de starts the line at column 0
            // column holds its last value through blanking
            if (de_in) begin
                col_q <= de_q ? col_q + col_t'(1) : '0;
            end
        end
    end

    // registered sample onto the pipeline
    assign pix.gray = gray_q;
    assign pix.col  = col_q;
    assign pix.de   = de_q;
    assign pix.hs   = hs_q;
    assign pix.vs   = vs_q;

endmodule

// ==== design/diffusion_taps.sv ====
`include "dither_defines.svh"

// chain of tap registers, each adds one error term to the passing pixel
// err[0] lands on the last stage, err[TAPS-1] on the first one
module diffusion_taps #(
    parameter int TAPS = 5
) (
    input  logic             clk,
    input  logic             rst,
    pix_if.dst               up,
    input  dither_pkg::err_t err [TAPS],
    pix_if.src               down
);
    import dither_pkg::*;

    // stage inputs
    acc_t gray_in [TAPS];
    col_t col_in  [TAPS];
    logic de_in   [TAPS];
    logic hs_in   [TAPS];
    logic vs_in   [TAPS];
    // sum of pixel and error, then clamped
    acc_t sum     [TAPS];
    acc_t sat     [TAPS];
    // stage registers
    acc_t gray_q  [TAPS];
    col_t col_q   [TAPS];
    logic de_q    [TAPS];
    logic hs_q    [TAPS];
    logic vs_q    [TAPS];

    for (genvar s = 0; s < TAPS; s++) begin : g_stage
        if (s == 0) begin : g_head
            assign gray_in[s] = up.gray;
            assign col_in[s]  = up.col;
            assign de_in[s]   = up.de;
            assign hs_in[s]   = up.hs;
            assign vs_in[s]   = up.vs;
        end else begin : g_link
            assign gray_in[s] = gray_q[s-1];
            assign col_in[s]  = col_q[s-1];
            assign de_in[s]   = de_q[s-1];
            assign hs_in[s]   = hs_q[s-1];
            assign vs_in[s]   = vs_q[s-1];
        end

        assign sum[s] = gray_in[s] + err[TAPS-1-s];
        // saturate to the legal gray range, no wrap
        assign sat[s] = (sum[s] < 0) ? '0 :
                        (sum[s] > acc_t'(`GRAY_MAX)) ? acc_t'(`GRAY_MAX) : sum[s];

        always_ff @(posedge clk) begin
            if (rst) begin
                gray_q[s] <= '0;
                col_q[s]  <= '0;
                de_q[s]   <= 1'b0;
                hs_q[s]   <= 1'b0;
                vs_q[s]   <= 1'b0;
            end else begin
                gray_q[s] <= sat[s];
                col_q[s]  <= col_in[s];
                de_q[s]   <= de_in[s];
                hs_q[s]   <= hs_in[s];
                vs_q[s]   <= vs_in[s];
            end
        end
    end

    assign down.gray = gray_q[TAPS-1];
    assign down.col  = col_q[TAPS-1];
    assign down.de   = de_q[TAPS-1];
    assign down.hs   = hs_q[TAPS-1];
    assign down.vs   = vs_q[TAPS-1];

endmodule

// ==== design/line_delay.sv ====
// fixed shift delay of whole pixel samples
// fills the gap between tap segments so rows line up vertically
module line_delay #(
    parameter int DEPTH = 19
) (
    input  logic clk,
    input  logic rst,
    pix_if.dst   up,
    pix_if.src   down
);
    import dither_pkg::*;

    acc_t gray_sr [DEPTH];
    col_t col_sr  [DEPTH];
    logic de_sr   [DEPTH];
    logic hs_sr   [DEPTH];
    logic vs_sr   [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                gray_sr[i] <= '0;
                col_sr[i]  <= '0;
                de_sr[i]   <= 1'b0;
                hs_sr[i]   <= 1'b0;
                vs_sr[i]   <= 1'b0;
            end
        end else begin
            // entry 0 takes the new sample
            gray_sr[0] <= up.gray;
            col_sr[0]  <= up.col;
            de_sr[0]   <= up.de;
            hs_sr[0]   <= up.hs;
            vs_sr[0]   <= up.vs;
            for (int i = 1; i < DEPTH; i++) begin
                gray_sr[i] <= gray_sr[i-1];
                col_sr[i]  <= col_sr[i-1];
                de_sr[i]   <= de_sr[i-1];
                hs_sr[i]   <= hs_sr[i-1];
                vs_sr[i]   <= vs_sr[i-1];
            end
        end
    end

    assign down.gray = gray_sr[DEPTH-1];
    assign down.col  = col_sr[DEPTH-1];
    assign down.de   = de_sr[DEPTH-1];
    assign down.hs   = hs_sr[DEPTH-1];
    assign down.vs   = vs_sr[DEPTH-1];

endmodule

// ==== design/error_quantizer.sv ====
`include "dither_defines.svh"

module error_quantizer (
    input  logic             clk,
    input  logic             rst,
    pix_if.dst               pix,
    output dither_pkg::err_t err_row  [`ROW0_TAPS],
    output dither_pkg::err_t err_near [`ROWN_TAPS],
    output dither_pkg::err_t err_far  [`ROWN_TAPS],
    output dither_pkg::rgb_t dout,
    output logic             hs_out,
    output logic             vs_out,
    output logic             de_out
);
    import dither_pkg::*;

    // ************************************************************
    // term gating
    // ************************************************************

    // drop a term outside active video or off either end of the line
    function automatic err_t gate(err_t w, col_t col, int off, logic de);
        int tgt;
        tgt = int'(col) + off;
        if (de && tgt >= 0 && tgt < `ACTIVE_W) begin
            return w;
        end
        return '0;
    endfunction

    acc_t level;
    acc_t q;
    err_t w7;
    err_t w5;
    err_t w3;
    err_t w1;
    rgb_t dout_q;
    logic hs_q;
    logic vs_q;
    logic de_q;

    // binarise, white at or above threshold
    assign level = (pix.gray >= acc_t'(`GRAY_THRESH)) ? acc_t'(`GRAY_MAX) : '0;
    // signed error, -127 .. 127
    assign q = pix.gray - level;

    // shift approximations of the 48ths of the kernel
    // 7/48 ~ 1/16 + 1/8 - 1/32
    assign w7 = (q >>> 4) + (q >>> 3) - (q >>> 5);
    // 5/48 ~ 1/8 - 1/64
    assign w5 = (q >>> 3) - (q >>> 6);
    // 3/48 = 1/16
    assign w3 = q >>> 4;
    // 1/48 ~ 1/64 + 1/128
    assign w1 = (q >>> 6) + (q >>> 7);

    // ************************************************************
    // weights per target offset
    // ************************************************************

    // same line, offsets +1 and +2
    assign err_row[0]  = gate(w7, pix.col, 1, pix.de);
    assign err_row[1]  = gate(w5, pix.col, 2, pix.de);

    // one line below, offsets -2 .. +2
    assign err_near[0] = gate(w3, pix.col, -2, pix.de);
    assign err_near[1] = gate(w5, pix.col, -1, pix.de);
    assign err_near[2] = gate(w7, pix.col, 0, pix.de);
    assign err_near[3] = gate(w5, pix.col, 1, pix.de);
    assign err_near[4] = gate(w3, pix.col, 2, pix.de);

    // two lines below
    assign err_far[0]  = gate(w1, pix.col, -2, pix.de);
    assign err_far[1]  = gate(w3, pix.col, -1, pix.de);
    assign err_far[2]  = gate(w5, pix.col, 0, pix.de);
    assign err_far[3]  = gate(w3, pix.col, 1, pix.de);
    assign err_far[4]  = gate(w1, pix.col, 2, pix.de);

    // output register, level copied onto all three colours
    always_ff @(posedge clk) begin
        if (rst) begin
            dout_q <= '0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
            de_q   <= 1'b0;
        end else begin
            dout_q <= {3{level[7:0]}};
            hs_q   <= pix.hs;
            vs_q   <= pix.vs;
            de_q   <= pix.de;
        end
    end

    assign dout   = dout_q;
    assign hs_out = hs_q;
    assign vs_out = vs_q;
    assign de_out = de_q;

endmodule

// ==== design/dither_top.sv ====
`include "dither_defines.svh"

module dither_top (
    input  logic             clk,
    input  logic             rst,
    input  dither_pkg::rgb_t din,
    input  logic             hs_in,
    input  logic             vs_in,
    input  logic             de_in,
    output dither_pkg::rgb_t dout,
    output logic             hs_out,
    output logic             vs_out,
    output logic             de_out
);
    import dither_pkg::*;

    // error buses from the quantizer back into the tap chains
    err_t err_row  [`ROW0_TAPS];
    err_t err_near [`ROWN_TAPS];
    err_t err_far  [`ROWN_TAPS];

    // ************************************************************
    // pipeline links, luma -> far -> delay -> near -> delay -> row -> quantizer
    // ************************************************************
    pix_if luma_far ();
    pix_if far_dly ();
    pix_if dly_near ();
    pix_if near_dly ();
    pix_if dly_row ();
    pix_if row_quant ();

    luma_stage luma_stage_i (
        .clk   (clk),
        .rst   (rst),
        .din   (din),
        .hs_in (hs_in),
        .vs_in (vs_in),
        .de_in (de_in),
        .pix   (luma_far.src)
    );

    // taps two lines below the quantized pixel
    diffusion_taps #(.TAPS(`ROWN_TAPS)) far_taps_i (
        .clk  (clk),
        .rst  (rst),
        .up   (luma_far.dst),
        .err  (err_far),
        .down (far_dly.src)
    );

    // delay plus tap count adds up to one line period
    line_delay #(.DEPTH(`LINE_TOTAL - `ROWN_TAPS)) far_delay_i (
        .clk  (clk),
        .rst  (rst),
        .up   (far_dly.dst),
        .down (dly_near.src)
    );

    // taps one line below
    diffusion_taps #(.TAPS(`ROWN_TAPS)) near_taps_i (
        .clk  (clk),
        .rst  (rst),
        .up   (dly_near.dst),
        .err  (err_near),
        .down (near_dly.src)
    );

    line_delay #(.DEPTH(`LINE_TOTAL - `ROWN_TAPS)) near_delay_i (
        .clk  (clk),
        .rst  (rst),
        .up   (near_dly.dst),
        .down (dly_row.src)
    );

    // taps to the right in the current line
    diffusion_taps #(.TAPS(`ROW0_TAPS)) row_taps_i (
        .clk  (clk),
        .rst  (rst),
        .up   (dly_row.dst),
        .err  (err_row),
        .down (row_quant.src)
    );

    error_quantizer error_quantizer_i (
        .clk      (clk),
        .rst      (rst),
        .pix      (row_quant.dst),
        .err_row  (err_row),
        .err_near (err_near),
        .err_far  (err_far),
        .dout     (dout),
        .hs_out   (hs_out),
        .vs_out   (vs_out),
        .de_out   (de_out)
    );

endmodule

// ==== verification/dither_tb.sv ====
`include "dither_defines.svh"

module dither_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import dither_pkg::*;

    // ************************************************************
    // frame geometry and run length
    // ************************************************************
    localparam int ROWS      = 8;
    localparam int VBLANK    = 3;
    localparam int LAT       = 2 * `LINE_TOTAL + 4;
    localparam int FRAME_CYC = (ROWS + VBLANK) * `LINE_TOTAL;
    // mid gray, white, black, red, green, blue, random
    localparam int N_FRAMES  = 7;
    // twice the stimulus length at 4 ns a cycle
    localparam int WATCHDOG_NS = 2 * N_FRAMES * FRAME_CYC * 4;

    // one driven sample and what must come out LAT cycles later
    typedef struct packed {
        int          cyc;
        logic [23:0] dout;
        logic        de;
        logic        hs;
        logic        vs;
    } expect_t;

    logic clk = 1'b0;
    logic rst;
    rgb_t din;
    logic hs_in;
    logic vs_in;
    logic de_in;
    rgb_t dout;
    logic hs_out;
    logic vs_out;
    logic de_out;

    int cyc = 0;
    int n_checks = 0;
    int n_errors = 0;
    expect_t exp_q [$];

    // active part of the current frame as driven and as the model quantizes it
    rgb_t       frame_rgb [ROWS][`ACTIVE_W];
    int         frame_acc [ROWS][`ACTIVE_W];
    logic [7:0] frame_lvl [ROWS][`ACTIVE_W];

    dither_top dither_top_i (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .hs_in  (hs_in),
        .vs_in  (vs_in),
        .de_in  (de_in),
        .dout   (dout),
        .hs_out (hs_out),
        .vs_out (vs_out),
        .de_out (de_out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ************************************************************
    // reference model
    // ************************************************************

    // gray level weighting red and blue by 1/4 and green by 1/2
    function automatic int gray_of(rgb_t p);
        return (int'(p[23:16]) >> 2) + (int'(p[15:8]) >> 1) + (int'(p[7:0]) >> 2);
    endfunction

    // add one error term to a pixel not yet quantized and clamp the sum
    // rows past the frame fall into vertical blanking and are dropped
    function automatic void add_term(int r, int c, int w);
        int v;
        if (r >= ROWS || c < 0 || c >= `ACTIVE_W) begin
            return;
        end
        v = frame_acc[r][c] + w;
        frame_acc[r][c] = (v < 0) ? 0 : ((v > `GRAY_MAX) ? `GRAY_MAX : v);
    endfunction

    // raster order jjn diffusion with the shift weights
    function automatic void compute_frame();
        int r;
        int c;
        int lvl;
        int q;
        int w7;
        int w5;
        int w3;
        int w1;
        for (r = 0; r < ROWS; r++) begin
            for (c = 0; c < `ACTIVE_W; c++) begin
                frame_acc[r][c] = gray_of(frame_rgb[r][c]);
            end
        end
        for (r = 0; r < ROWS; r++) begin
            for (c = 0; c < `ACTIVE_W; c++) begin
                lvl = (frame_acc[r][c] >= `GRAY_THRESH) ? `GRAY_MAX : 0;
                frame_lvl[r][c] = 8'(lvl);
                q  = frame_acc[r][c] - lvl;
                w7 = (q >>> 4) + (q >>> 3) - (q >>> 5);
                w5 = (q >>> 3) - (q >>> 6);
                w3 = q >>> 4;
                w1 = (q >>> 6) + (q >>> 7);
                // current line to the right of the pixel
                add_term(r, c + 1, w7);
                add_term(r, c + 2, w5);
                // next line
                add_term(r + 1, c - 2, w3);
                add_term(r + 1, c - 1, w5);
                add_term(r + 1, c, w7);
                add_term(r + 1, c + 1, w5);
                add_term(r + 1, c + 2, w3);
                // two lines down
                add_term(r + 2, c - 2, w1);
                add_term(r + 2, c - 1, w3);
                add_term(r + 2, c, w5);
                add_term(r + 2, c + 1, w3);
                add_term(r + 2, c + 2, w1);
            end
        end
    endfunction

    // ************************************************************
    // stimulus
    // ************************************************************

    task automatic fill_frame(input int kind);
        int r;
        int c;
        for (r = 0; r < ROWS; r++) begin
            for (c = 0; c < `ACTIVE_W; c++) begin
                case (kind)
                    0: frame_rgb[r][c] = 24'h808080;
                    1: frame_rgb[r][c] = 24'hFFFFFF;
                    2: frame_rgb[r][c] = 24'h000000;
                    3: frame_rgb[r][c] = 24'hFF0000;
                    4: frame_rgb[r][c] = 24'h00FF00;
                    5: frame_rgb[r][c] = 24'h0000FF;
                    default: frame_rgb[r][c] = rgb_t'($urandom());
                endcase
            end
        end
    endtask

    // one full frame with a sample per clock driven 1 ns after each rising edge
    task automatic drive_frame();
        int line;
        int s;
        expect_t e;
        for (line = 0; line < ROWS + VBLANK; line++) begin
            for (s = 0; s < `LINE_TOTAL; s++) begin
                e.cyc  = cyc;
                e.de   = (line < ROWS) && (s < `ACTIVE_W);
                // hs pulse inside horizontal blanking
                e.hs   = (s >= `ACTIVE_W + 2) && (s < `ACTIVE_W + 6);
                e.vs   = (line >= ROWS);
                e.dout = '0;
                din    = '0;
                if (e.de) begin
                    din    = frame_rgb[line][s];
                    e.dout = {3{frame_lvl[line][s]}};
                end
                de_in = e.de;
                hs_in = e.hs;
                vs_in = e.vs;
                exp_q.push_back(e);
                @(posedge clk);
                #1;
            end
        end
    endtask

    // ************************************************************
    // checking
    // ************************************************************

    task automatic report_mismatch(input string name, input logic [23:0] expv,
                                   input logic [23:0] actv);
        n_errors++;
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expv, actv);
    endtask

    task automatic check_sample(input expect_t e);
        n_checks++;
        if (de_out !== e.de) begin
            report_mismatch("de_out", 24'(e.de), 24'(de_out));
        end
        if (hs_out !== e.hs) begin
            report_mismatch("hs_out", 24'(e.hs), 24'(hs_out));
        end
        if (vs_out !== e.vs) begin
            report_mismatch("vs_out", 24'(e.vs), 24'(vs_out));
        end
        // dout only carries a pixel while de is high
        if (e.de) begin
            if (dout !== e.dout) begin
                report_mismatch("dout", e.dout, dout);
            end
            if (dout[23:16] !== dout[7:0] || dout[15:8] !== dout[7:0]) begin
                n_errors++;
                $display("[FAIL] t=%0t dout colour bytes are not equal: %06h", $time, dout);
            end
        end
    endtask

    // outputs are compared at the falling edge between register updates
    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            if (exp_q.size() != 0 && cyc - exp_q[0].cyc == LAT) begin
                e = exp_q.pop_front();
                check_sample(e);
            end else begin
                // strobes stay low until the first sample is due
                n_checks++;
                if (de_out !== 1'b0 || hs_out !== 1'b0 || vs_out !== 1'b0) begin
                    n_errors++;
                    $display("[FAIL] t=%0t strobes high with no sample due: de %b hs %b vs %b",
                             $time, de_out, hs_out, vs_out);
                end
            end
        end
    end

    // ************************************************************
    // main sequence and watchdog
    // ************************************************************

    initial begin
        int f;
        // inputs held busy through reset so an uncleared register shows at the outputs
        rst   = 1'b1;
        din   = 24'hFFFFFF;
        hs_in = 1'b1;
        vs_in = 1'b1;
        de_in = 1'b1;
        void'($urandom(32'h5211));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (f = 0; f < N_FRAMES; f++) begin
            fill_frame(f);
            compute_frame();
            drive_frame();
        end
        // idle inputs while the last frame drains
        din   = '0;
        hs_in = 1'b0;
        vs_in = 1'b0;
        de_in = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the output never drained", WATCHDOG_NS);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== dither_top.f ====
+incdir+include
design/dither_pkg.sv
design/pix_if.sv
design/luma_stage.sv
design/diffusion_taps.sv
design/line_delay.sv
design/error_quantizer.sv
design/dither_top.sv
verification/dither_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the dither testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f dither_top.f --top-module dither_tb -Mdir obj_dir > build.log 2>&1 &&
    ./obj_dir/Vdither_tb > sim.log 2>&1 ||
    echo "build or simulation did not complete, see build.log and sim.log"

grep -q "Simulation PASSED" sim.log 2>/dev/null && echo "dither: pass" ||
    { echo "dither: fail"; exit 1; }
